// File: vga_master.f
src/vga_pkg.sv
src/vga_dpram.sv
src/vga_timing.sv
src/vga_regs.sv
src/vga_fetch.sv
src/vga_master.sv
dv/vga_master_sva.sv
dv/tb_vga_master.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, status follows the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_vga_master -f vga_master.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Finished with no errors" \
  || exit 1

// File: dv/tb_vga_master.sv
`timescale 1ns/1ps

module tb_vga_master
  import vga_pkg::*;
();

  localparam int HA = 32;
  localparam int HF = 4;
  localparam int HS = 4;
  localparam int HB = 4;
  localparam int VA = 6;
  localparam int VF = 2;
  localparam int VS = 2;
  localparam int VB = 2;
  localparam int H_TOTAL = HA + HF + HS + HB;
  localparam int V_TOTAL = VA + VF + VS + VB;
  localparam int WORDS = HA / 4;
  localparam int VS_LIMIT = 2 * H_TOTAL * V_TOTAL + 10;
  localparam logic [31:0] SEED = 32'd5101;

  logic        clk_i;
  logic        vga_clk_i;
  logic        rst_i;
  logic [31:0] master_adr_o;
  logic        master_cyc_o;
  logic        master_stb_o;
  logic        master_we_o;
  logic [3:0]  master_sel_o;
  logic [31:0] master_dat_o;
  logic [31:0] master_dat_i;
  logic        master_ack_i;
  logic [9:0]  slave_adr_i;
  logic [31:0] slave_dat_i;
  logic [3:0]  slave_sel_i;
  logic        slave_we_i;
  logic        slave_cyc_i;
  logic        slave_stb_i;
  logic [31:0] slave_dat_o;
  logic        slave_ack_o;
  logic        hs_o;
  logic        vs_o;
  logic [7:0]  r_o;
  logic [7:0]  g_o;
  logic [7:0]  b_o;
  logic        blank_n_o;

  // expected display state, kept in step with the register writes
  logic [31:0] ref_base;
  logic [1:0]  ref_mode;
  logic        ref_sel;
  rgb_t        pal_copy [2][256];
  logic [31:0] rng;
  logic [31:0] wait_rng;
  logic [31:0] rd_data;
  logic [31:0] exp_adr;
  rgb_t        exp_pix;
  logic        chk_on;
  logic        tim_on;
  logic        hs_d;
  logic        vs_d;
  logic        bl_d;
  int bus_wait;
  int trk_row;
  int trk_word;
  int px;
  int py;
  int hs_cnt;
  int vs_len;
  int line_cnt;
  int tim_frames;
  int addr_cnt;
  int pix_norm;
  int pix_dbl;
  int err_reg;
  int err_bsel;
  int err_addr;
  int err_norm;
  int err_dbl;
  int err_tim;
  int total;

  vga_master #(
    .H_ACTIVE (HA),
    .H_FRONT  (HF),
    .H_SYNC   (HS),
    .H_BACK   (HB),
    .V_ACTIVE (VA),
    .V_FRONT  (VF),
    .V_SYNC   (VS),
    .V_BACK   (VB)
  ) uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .vga_clk_i    (vga_clk_i),
    .master_adr_o (master_adr_o),
    .master_cyc_o (master_cyc_o),
    .master_stb_o (master_stb_o),
    .master_we_o  (master_we_o),
    .master_sel_o (master_sel_o),
    .master_dat_o (master_dat_o),
    .master_dat_i (master_dat_i),
    .master_ack_i (master_ack_i),
    .slave_adr_i  (slave_adr_i),
    .slave_dat_i  (slave_dat_i),
    .slave_sel_i  (slave_sel_i),
    .slave_we_i   (slave_we_i),
    .slave_cyc_i  (slave_cyc_i),
    .slave_stb_i  (slave_stb_i),
    .slave_dat_o  (slave_dat_o),
    .slave_ack_o  (slave_ack_o),
    .hs_o         (hs_o),
    .vs_o         (vs_o),
    .r_o          (r_o),
    .g_o          (g_o),
    .b_o          (b_o),
    .blank_n_o    (blank_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    vga_clk_i = 1'b0;
    forever #5 vga_clk_i = ~vga_clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] v);
    logic [31:0] s;
    s = v;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // framebuffer contents seen by the fetch
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return xorshift32(adr ^ SEED);
  endfunction

  function automatic logic [31:0] row_offset(input int row);
    if (ref_mode == MODE_DOUBLE) begin
      return 32'((row / 2) * (HA / 2));
    end
    return 32'(row * HA);
  endfunction

  function automatic rgb_t ref_pixel(input int x, input int y);
    logic [31:0] adr;
    logic [31:0] w;
    int col;
    int lane;
    col  = (ref_mode == MODE_DOUBLE) ? x / 2 : x;
    adr  = ref_base + row_offset(y) + 32'((col / 4) * 4);
    lane = col % 4;
    w    = mem_word(adr);
    // byte 3 is the leftmost pixel
    return pal_copy[ref_sel][w[31-8*lane -: 8]];
  endfunction

  // name of the pixel test that runs in the current mode
  function automatic string pixel_test();
    if (ref_mode == MODE_DOUBLE) begin
      return "double_mode";
    end
    return "normal_mode";
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic bus_access(input logic [9:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rd);
    int n;
    @(posedge clk_i);
    slave_adr_i <= adr;
    slave_dat_i <= dat;
    slave_sel_i <= sel;
    slave_we_i  <= we;
    slave_cyc_i <= 1'b1;
    slave_stb_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!slave_ack_o && n < 20);
    if (!slave_ack_o) begin
      abort_run("slave bus access was never acked");
    end else begin
      rd = slave_dat_o;
      slave_cyc_i <= 1'b0;
      slave_stb_i <= 1'b0;
      slave_we_i  <= 1'b0;
    end
  endtask

  task automatic wait_vs_rise();
    int n;
    n = 0;
    while (vs_o && n < VS_LIMIT) begin
      @(posedge vga_clk_i);
      n++;
    end
    while (!vs_o && n < VS_LIMIT) begin
      @(posedge vga_clk_i);
      n++;
    end
    if (n >= VS_LIMIT) begin
      abort_run("vertical sync did not arrive in time");
    end
  endtask

  task automatic load_palette(input logic bank);
    logic [31:0] rd;
    for (int i = 0; i < 256; i++) begin
      rng = xorshift32(rng);
      pal_copy[bank][i] = rng[23:0];
      bus_access({1'b0, bank, 8'(i)}, {8'h0, rng[23:0]}, 4'hf, 1'b1, rd);
    end
  endtask

  task automatic check_reg(input string name, input logic [9:0] adr,
                           input logic [31:0] exp, inout int errs);
    logic [31:0] rd;
    bus_access(adr, 32'h0, 4'hf, 1'b0, rd);
    if (rd !== exp) begin
      $display("FAIL %s exp %h got %h", name, exp, rd);
      errs++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // memory model on the master port, also tracks the expected fetch address
  always @(posedge clk_i) begin
    master_ack_i <= 1'b0;
    if (!rst_i && master_cyc_o && master_stb_o && !master_ack_i) begin
      if (bus_wait == 0) begin
        exp_adr = ref_base + row_offset(trk_row) + 32'(trk_word * 4);
        if (chk_on) begin
          addr_cnt++;
          if (master_adr_o !== exp_adr) begin
            $display("FAIL master_addr exp %h got %h", exp_adr, master_adr_o);
            err_addr++;
          end
          // read only master with all byte lanes and no write data
          if (master_we_o !== 1'b0 || master_sel_o !== 4'hf || master_dat_o !== 32'h0) begin
            $display("FAIL master_addr we/sel/dat exp 0/f/%h got %b/%h/%h",
                     32'h0, master_we_o, master_sel_o, master_dat_o);
            err_addr++;
          end
        end
        master_dat_i <= mem_word(master_adr_o);
        master_ack_i <= 1'b1;
        wait_rng = xorshift32(wait_rng);
        bus_wait <= int'(wait_rng % 32'd4);
        if (trk_word == ((ref_mode == MODE_DOUBLE) ? WORDS / 2 - 1 : WORDS - 1)) begin
          trk_word = 0;
          trk_row  = (trk_row == VA - 1) ? 0 : trk_row + 1;
        end else begin
          trk_word++;
        end
      end else begin
        bus_wait <= bus_wait - 1;
      end
    end
  end

  // pixel and sync compare on the pixel clock
  always @(posedge vga_clk_i) begin
    if (!rst_i) begin
      if (vs_o && !vs_d) begin
        if (tim_on) begin
          tim_frames++;
          if (hs_cnt != V_TOTAL || line_cnt != VA) begin
            $display("FAIL sync_timing exp %0d/%0d got %0d/%0d",
                     V_TOTAL, VA, hs_cnt, line_cnt);
            err_tim++;
          end
        end
        tim_on   = 1'b1;
        hs_cnt   = 0;
        line_cnt = 0;
        py       = 0;
        vs_len   = 1;
      end else if (vs_o) begin
        vs_len++;
      end else if (vs_d && tim_on && vs_len != VS * H_TOTAL) begin
        $display("FAIL sync_timing vs_width exp %0d got %0d", VS * H_TOTAL, vs_len);
        err_tim++;
      end
      if (hs_o && !hs_d) begin
        hs_cnt++;
      end
      if (blank_n_o) begin
        if (chk_on) begin
          exp_pix = ref_pixel(px, py);
          if (ref_mode == MODE_DOUBLE) begin
            pix_dbl++;
          end else begin
            pix_norm++;
          end
          if ({r_o, g_o, b_o} !== exp_pix) begin
            $display("FAIL %s pixel (%0d,%0d) exp %h got %h", pixel_test(), px, py,
                     exp_pix, {r_o, g_o, b_o});
            if (ref_mode == MODE_DOUBLE) begin
              err_dbl++;
            end else begin
              err_norm++;
            end
          end
        end
        px++;
      end else begin
        if (chk_on && {r_o, g_o, b_o} !== 24'h0) begin
          $display("FAIL %s blank_rgb exp %h got %h", pixel_test(), 24'h0, {r_o, g_o, b_o});
          if (ref_mode == MODE_DOUBLE) begin
            err_dbl++;
          end else begin
            err_norm++;
          end
        end
        if (bl_d) begin
          if (tim_on && px != HA) begin
            $display("FAIL sync_timing active_width exp %0d got %0d", HA, px);
            err_tim++;
          end
          line_cnt++;
          py++;
          px = 0;
        end
      end
      hs_d = hs_o;
      vs_d = vs_o;
      bl_d = blank_n_o;
    end
  end

  initial begin
    #200000;
    abort_run("simulation ran past its time limit");
  end

  initial begin
    rst_i        = 1'b1;
    slave_adr_i  = 10'h0;
    slave_dat_i  = 32'h0;
    slave_sel_i  = 4'h0;
    slave_we_i   = 1'b0;
    slave_cyc_i  = 1'b0;
    slave_stb_i  = 1'b0;
    master_dat_i = 32'h0;
    master_ack_i = 1'b0;
    ref_base     = BASE_RESET;
    ref_mode     = MODE_NORMAL;
    ref_sel      = 1'b0;
    rng          = SEED;
    wait_rng     = xorshift32(SEED);
    chk_on       = 1'b0;
    tim_on       = 1'b0;
    hs_d         = 1'b0;
    vs_d         = 1'b0;
    bl_d         = 1'b0;
    trk_row      = 1;
    trk_word     = 0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // register accesses stay inside vertical sync, where no fetch runs
    wait_vs_rise();
    check_reg("reset_base", REG_BASE_IDX, BASE_RESET, err_reg);
    check_reg("reset_setup", REG_SETUP_IDX, 32'h0, err_reg);
    check_reg("unmapped", 10'h302, 32'h0, err_reg);
    report_test("reg_reset", err_reg);
    bus_access(REG_BASE_IDX, 32'h1122_3344, 4'b0101, 1'b1, rd_data);
    check_reg("base_bytes", REG_BASE_IDX, 32'hC022_0044, err_bsel);
    bus_access(REG_SETUP_IDX, 32'hFFFF_FFFF, 4'b0010, 1'b1, rd_data);
    check_reg("setup_bytes", REG_SETUP_IDX, 32'h0000_FF00, err_bsel);
    bus_access(REG_SETUP_IDX, 32'h0, 4'hf, 1'b1, rd_data);
    bus_access(REG_BASE_IDX, 32'h0000_8000, 4'hf, 1'b1, rd_data);
    ref_base = 32'h0000_8000;
    report_test("byte_select", err_bsel);

    load_palette(1'b0);
    wait_vs_rise();
    wait_vs_rise();
    chk_on = 1'b1;
    wait_vs_rise();
    chk_on = 1'b0;
    if (pix_norm == 0) begin
      $display("no pixels were compared in normal mode");
      err_norm++;
    end
    report_test("normal_mode", err_norm);

    load_palette(1'b1);
    wait_vs_rise();
    bus_access(REG_SETUP_IDX, 32'h0000_0100 | 32'(MODE_DOUBLE), 4'hf, 1'b1, rd_data);
    bus_access(REG_BASE_IDX, 32'h0002_0000, 4'hf, 1'b1, rd_data);
    ref_mode = MODE_DOUBLE;
    ref_sel  = 1'b1;
    ref_base = 32'h0002_0000;
    wait_vs_rise();
    wait_vs_rise();
    chk_on = 1'b1;
    wait_vs_rise();
    chk_on = 1'b0;
    if (pix_dbl == 0) begin
      $display("no pixels were compared in double mode");
      err_dbl++;
    end
    report_test("double_mode", err_dbl);

    if (addr_cnt == 0) begin
      $display("no master addresses were compared");
      err_addr++;
    end
    report_test("master_addr", err_addr);
    if (tim_frames == 0) begin
      $display("no complete frame was timed");
      err_tim++;
    end
    report_test("sync_timing", err_tim);

    total = err_reg + err_bsel + err_addr + err_norm + err_dbl + err_tim;
    $display("tests 6 errors %0d pixels %0d addresses %0d", total, pix_norm + pix_dbl, addr_cnt);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/vga_master_sva.sv
`timescale 1ns/1ps

module vga_master_sva (
  input logic clk_i,
  input logic rst_i,
  input logic cyc_i,
  input logic stb_i,
  input logic we_i,
  input logic ack_i,
  input logic slave_ack_i
);

  // a started master request stays up until it is acked
  a_stb_held: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i && !ack_i |=> stb_i)
    else $error("master stb dropped before ack");

  // display fetch is read only
  a_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i |-> !we_i)
    else $error("master bus write seen");

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    slave_ack_i |=> !slave_ack_i)
    else $error("slave ack longer than one cycle");

endmodule

bind vga_master vga_master_sva u_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cyc_i       (master_cyc_o),
  .stb_i       (master_stb_o),
  .we_i        (master_we_o),
  .ack_i       (master_ack_i),
  .slave_ack_i (slave_ack_o)
);

// File: src/vga_master.sv
`timescale 1ns/1ps

module vga_master
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        vga_clk_i,
  output logic [31:0] master_adr_o,
  output logic        master_cyc_o,
  output logic        master_stb_o,
  output logic        master_we_o,
  output logic [3:0]  master_sel_o,
  output logic [31:0] master_dat_o,
  input  logic [31:0] master_dat_i,
  input  logic        master_ack_i,
  input  logic [9:0]  slave_adr_i,
  input  logic [31:0] slave_dat_i,
  input  logic [3:0]  slave_sel_i,
  input  logic        slave_we_i,
  input  logic        slave_cyc_i,
  input  logic        slave_stb_i,
  output logic [31:0] slave_dat_o,
  output logic        slave_ack_o,
  output logic        hs_o,
  output logic        vs_o,
  output logic [7:0]  r_o,
  output logic [7:0]  g_o,
  output logic [7:0]  b_o,
  output logic        blank_n_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int WORD_W  = $clog2(H_ACTIVE / 4);
  localparam int LB_AW   = WORD_W + 1;

  logic [31:0]      vga_base;
  logic [1:0]       mode;
  logic             pal_sel;
  logic             pal_we;
  logic             pal_bank;
  logic [7:0]       pal_addr;
  rgb_t             pal_data;
  logic [31:0]      pal_idx;
  logic             lb_we;
  logic [LB_AW-1:0] lb_addr;
  logic [LB_AW-1:0] lb_rd_addr;
  logic [15:0]      x;
  logic [15:0]      y;
  logic [15:0]      nx;
  logic [15:0]      ny;
  logic             line_start;
  logic             ls_toggle;
  logic             blank_n;
  logic             pix_double;
  logic [1:0]       lane;
  rgb_t             pal_q [4];
  rgb_t             lb_q [4];
  rgb_t             pix;

  assign master_we_o  = 1'b0;
  assign master_sel_o = 4'hf;
  assign master_dat_o = 32'h0;

  vga_regs u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .slave_adr_i (slave_adr_i),
    .slave_dat_i (slave_dat_i),
    .slave_sel_i (slave_sel_i),
    .slave_we_i  (slave_we_i),
    .slave_cyc_i (slave_cyc_i),
    .slave_stb_i (slave_stb_i),
    .slave_dat_o (slave_dat_o),
    .slave_ack_o (slave_ack_o),
    .vga_base_o  (vga_base),
    .mode_o      (mode),
    .pal_sel_o   (pal_sel),
    .pal_we_o    (pal_we),
    .pal_bank_o  (pal_bank),
    .pal_addr_o  (pal_addr),
    .pal_data_o  (pal_data)
  );

  vga_fetch #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .line_start_i (ls_toggle),
    .vga_base_i   (vga_base),
    .mode_i       (mode),
    .master_dat_i (master_dat_i),
    .master_ack_i (master_ack_i),
    .master_adr_o (master_adr_o),
    .master_cyc_o (master_cyc_o),
    .master_stb_o (master_stb_o),
    .pal_idx_o    (pal_idx),
    .lb_we_o      (lb_we),
    .lb_addr_o    (lb_addr)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk_i        (vga_clk_i),
    .rst_i        (rst_i),
    .x_o          (x),
    .y_o          (y),
    .hs_o         (hs_o),
    .vs_o         (vs_o),
    .blank_n_o    (blank_n),
    .line_start_o (line_start)
  );

  // toggle source for the synchronizer in the fetch
  always_ff @(posedge vga_clk_i or posedge rst_i) begin
    if (rst_i) begin
      ls_toggle <= 1'b0;
    end else if (line_start) begin
      ls_toggle <= ~ls_toggle;
    end
  end

  // lane k holds pixel 4*word+k, each lane with its own palette copy
  for (genvar k = 0; k < 4; k++) begin : g_lane
    vga_dpram #(
      .DATA_W ($bits(rgb_t)),
      .ADDR_W (9)
    ) u_pal (
      .wr_clk_i  (clk_i),
      .wr_en_i   (pal_we),
      .wr_addr_i ({pal_bank, pal_addr}),
      .wr_data_i (pal_data),
      .rd_clk_i  (clk_i),
      .rd_addr_i ({pal_sel, pal_idx[31-8*k -: 8]}),
      .rd_data_o (pal_q[k])
    );

    vga_dpram #(
      .DATA_W ($bits(rgb_t)),
      .ADDR_W (LB_AW)
    ) u_linebuf (
      .wr_clk_i  (clk_i),
      .wr_en_i   (lb_we),
      .wr_addr_i (lb_addr),
      .wr_data_i (pal_q[k]),
      .rd_clk_i  (vga_clk_i),
      .rd_addr_i (lb_rd_addr),
      .rd_data_o (lb_q[k])
    );
  end

  // read one pixel ahead, including the wrap into the next line
  always_comb begin
    nx = x + 16'd1;
    ny = y;
    if (x == 16'(H_TOTAL - 1)) begin
      nx = 16'd0;
      ny = (y == 16'(V_TOTAL - 1)) ? 16'd0 : y + 16'd1;
    end
  end

  assign pix_double = (mode == MODE_DOUBLE);
  assign lb_rd_addr = pix_double ? {ny[0], nx[WORD_W+2:3]} : {ny[0], nx[WORD_W+1:2]};
  assign lane       = pix_double ? x[2:1] : x[1:0];
  assign pix        = blank_n ? lb_q[lane] : rgb_t'(24'h0);

  assign r_o       = pix[23:16];
  assign g_o       = pix[15:8];
  assign b_o       = pix[7:0];
  assign blank_n_o = blank_n;

endmodule

// File: src/vga_fetch.sv
`timescale 1ns/1ps

module vga_fetch
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         line_start_i,
  input  logic [31:0]                  vga_base_i,
  input  logic [1:0]                   mode_i,
  input  logic [31:0]                  master_dat_i,
  input  logic                         master_ack_i,
  output logic [31:0]                  master_adr_o,
  output logic                         master_cyc_o,
  output logic                         master_stb_o,
  output logic [31:0]                  pal_idx_o,
  output logic                         lb_we_o,
  output logic [$clog2(H_ACTIVE/4):0]  lb_addr_o
);

  localparam int WORDS_N = H_ACTIVE / 4;
  localparam int WORD_W  = $clog2(WORDS_N);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_PAL, ST_STORE} state_t;

  state_t            state;
  logic [2:0]        ls_sync;
  logic              ls_edge;
  logic              pend;
  logic              start;
  logic [15:0]       row;
  logic [WORD_W-1:0] word;
  logic [WORD_W-1:0] last_word;
  logic [31:0]       row_off;
  logic              pix_double;

  // line_start_i is a toggle from the pixel clock domain
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ls_sync <= 3'b000;
    end else begin
      ls_sync <= {ls_sync[1:0], line_start_i};
    end
  end

  assign ls_edge    = ls_sync[2] ^ ls_sync[1];
  assign start      = (state == ST_IDLE) && (pend || ls_edge);
  assign pix_double = (mode_i == MODE_DOUBLE);
  assign last_word  = pix_double ? WORD_W'(WORDS_N / 2 - 1) : WORD_W'(WORDS_N - 1);

  // double mode shows each framebuffer row on two lines at half width
  assign row_off = pix_double ? 32'(row >> 1) * 32'(H_ACTIVE / 2)
                              : 32'(row) * 32'(H_ACTIVE);

  assign master_adr_o = vga_base_i + row_off + (32'(word) << 2);
  assign master_cyc_o = (state == ST_BUS);
  assign master_stb_o = (state == ST_BUS);

  // palette output is valid in ST_STORE, two cycles after the word was latched
  assign lb_we_o   = (state == ST_STORE);
  assign lb_addr_o = {row[0], word};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= ST_IDLE;
      pend  <= 1'b0;
      row   <= 16'd1;
      word  <= '0;
    end else begin
      pend <= start ? (pend & ls_edge) : (pend | ls_edge);
      case (state)
        ST_IDLE: begin
          if (start) begin
            word  <= '0;
            state <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (master_ack_i) begin
            state <= ST_PAL;
          end
        end
        ST_PAL: state <= ST_STORE;
        default: begin
          if (word == last_word) begin
            word  <= '0;
            row   <= (row == 16'(V_ACTIVE - 1)) ? 16'd0 : row + 16'd1;
            state <= ST_IDLE;
          end else begin
            word  <= word + 1'b1;
            state <= ST_BUS;
          end
        end
      endcase
    end
  end

  // four colour indices, byte 3 is the leftmost pixel
  always_ff @(posedge clk_i) begin
    if (state == ST_BUS && master_ack_i) begin
      pal_idx_o <= master_dat_i;
    end
  end

endmodule

// File: src/vga_regs.sv
`timescale 1ns/1ps

module vga_regs
  import vga_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [9:0]  slave_adr_i,
  input  logic [31:0] slave_dat_i,
  input  logic [3:0]  slave_sel_i,
  input  logic        slave_we_i,
  input  logic        slave_cyc_i,
  input  logic        slave_stb_i,
  output logic [31:0] slave_dat_o,
  output logic        slave_ack_o,
  output logic [31:0] vga_base_o,
  output logic [1:0]  mode_o,
  output logic        pal_sel_o,
  output logic        pal_we_o,
  output logic        pal_bank_o,
  output logic [7:0]  pal_addr_o,
  output logic [23:0] pal_data_o
);

  typedef enum logic [1:0] {S_IDLE, S_PAL, S_DONE} state_t;

  state_t      state;
  logic [31:0] base_q;
  logic [31:0] setup_q;
  logic [31:0] rd_val;
  logic        req;
  logic        is_pal;
  logic        hit_base;
  logic        hit_setup;

  function automatic logic [31:0] byte_merge(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign req       = slave_cyc_i && slave_stb_i && (state == S_IDLE);
  // 0x000-0x1ff is palette space, everything above is registers
  assign is_pal    = ~slave_adr_i[9];
  assign hit_base  = (slave_adr_i == REG_BASE_IDX);
  assign hit_setup = (slave_adr_i == REG_SETUP_IDX);

  always_comb begin
    rd_val = 32'h0;
    if (!slave_we_i && hit_base) begin
      rd_val = base_q;
    end else if (!slave_we_i && hit_setup) begin
      rd_val = setup_q;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state       <= S_IDLE;
      base_q      <= BASE_RESET;
      setup_q     <= 32'h0;
      slave_dat_o <= 32'h0;
      pal_we_o    <= 1'b0;
    end else begin
      pal_we_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (req) begin
            slave_dat_o <= rd_val;
            if (is_pal) begin
              // RAM write lands in the cycle between request and ack
              pal_we_o <= slave_we_i;
              state    <= S_PAL;
            end else begin
              state <= S_DONE;
              if (slave_we_i && hit_base) begin
                base_q <= byte_merge(base_q, slave_dat_i, slave_sel_i);
              end
              if (slave_we_i && hit_setup) begin
                setup_q <= byte_merge(setup_q, slave_dat_i, slave_sel_i);
              end
            end
          end
        end
        S_PAL:   state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && is_pal) begin
      pal_bank_o <= slave_adr_i[8];
      pal_addr_o <= slave_adr_i[7:0];
      pal_data_o <= slave_dat_i[23:0];
    end
  end

  assign slave_ack_o = (state == S_DONE);
  assign vga_base_o  = base_q;
  assign mode_o      = setup_q[1:0];
  assign pal_sel_o   = setup_q[SETUP_PAL_BIT];

endmodule

// File: src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic        clk_i,
  input  logic        rst_i,
  output logic [15:0] x_o,
  output logic [15:0] y_o,
  output logic        hs_o,
  output logic        vs_o,
  output logic        blank_n_o,
  output logic        line_start_o
);

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  logic [15:0] h_nxt;
  logic [15:0] v_nxt;

  always_comb begin
    h_nxt = x_o + 16'd1;
    v_nxt = y_o;
    if (x_o == 16'(H_TOTAL - 1)) begin
      h_nxt = 16'd0;
      v_nxt = (y_o == 16'(V_TOTAL - 1)) ? 16'd0 : y_o + 16'd1;
    end
  end

  // counters start on the last position so the first frame begins cleanly
  // outputs are decoded from the next position, which keeps them in step
  // with the registered line buffer read
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      x_o          <= 16'(H_TOTAL - 1);
      y_o          <= 16'(V_TOTAL - 1);
      hs_o         <= 1'b0;
      vs_o         <= 1'b0;
      blank_n_o    <= 1'b0;
      line_start_o <= 1'b0;
    end else begin
      x_o          <= h_nxt;
      y_o          <= v_nxt;
      hs_o         <= (h_nxt >= 16'(HS_START)) && (h_nxt < 16'(HS_END));
      vs_o         <= (v_nxt >= 16'(VS_START)) && (v_nxt < 16'(VS_END));
      blank_n_o    <= (h_nxt < 16'(H_ACTIVE)) && (v_nxt < 16'(V_ACTIVE));
      line_start_o <= (h_nxt == 16'd0) && (v_nxt < 16'(V_ACTIVE));
    end
  end

endmodule

// File: src/vga_dpram.sv
`timescale 1ns/1ps

module vga_dpram #(
  parameter int DATA_W = 24,
  parameter int ADDR_W = 9
) (
  input  logic              wr_clk_i,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              rd_clk_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge wr_clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // one cycle read latency on the read clock
  always_ff @(posedge rd_clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: src/vga_pkg.sv
package vga_pkg;

  // one displayed pixel, red in the top byte and blue in the bottom byte
  typedef logic [23:0] rgb_t;

  // word indices in the 10-bit slave address space
  localparam logic [9:0] REG_BASE_IDX  = 10'h300;
  localparam logic [9:0] REG_SETUP_IDX = 10'h301;

  // vga_setup[1:0]
  localparam logic [1:0] MODE_NORMAL = 2'b00;
  localparam logic [1:0] MODE_DOUBLE = 2'b01;

  // vga_setup bit that picks palette 1 over palette 0
  localparam int SETUP_PAL_BIT = 8;

  // framebuffer byte address after reset
  localparam logic [31:0] BASE_RESET = 32'hC000_0000;

endpackage
